//--- cache_top.f
logic/cache_pkg.sv
logic/cache_meta_array.sv
logic/cache_data_array.sv
logic/cache_controller.sv
logic/cache_top.sv
tb/cache_tb.sv

//--- logic/cache_controller.sv
`timescale 1ns/10ps
`default_nettype none

module cache_controller (
  input  logic                    clk,
  input  logic                    reset,

  input  logic                    cpu_req_valid,
  input  cache_pkg::cpu_req_t     cpu_req,
  output logic                    cpu_req_ready,
  output logic                    cpu_resp_valid,
  output cache_pkg::word_t        cpu_resp_data,

  output logic                    mem_req_valid,
  output cache_pkg::beat_addr_t   mem_req_addr,
  output logic                    mem_req_rw,
  output logic                    mem_req_data_valid,
  output cache_pkg::beat_t        mem_req_data,
  input  logic                    mem_req_ready,
  input  logic                    mem_req_data_ready,
  input  logic                    mem_resp_valid,
  input  cache_pkg::beat_t        mem_resp_data,

  output cache_pkg::line_index_t  meta_index,
  output cache_pkg::tag_t         lookup_tag,
  output logic                    meta_write_en,
  output cache_pkg::meta_entry_t  meta_write_entry,
  input  cache_pkg::meta_entry_t  meta_entry,
  input  logic                    meta_hit,

  output cache_pkg::line_index_t  data_index,
  output cache_pkg::beat_sel_t    data_beat,
  output cache_pkg::data_write_t  data_write,
  input  cache_pkg::beat_t        data_read_beat
);

  cache_pkg::cache_state_t state;
  cache_pkg::cache_state_t next_state;
  cache_pkg::cpu_req_t     req_q;
  cache_pkg::tag_t         req_tag;
  cache_pkg::tag_t         victim_tag_q;
  cache_pkg::line_index_t  req_index;
  cache_pkg::line_index_t  sweep_count;
  cache_pkg::beat_sel_t    req_beat;
  cache_pkg::beat_sel_t    beat_count;
  cache_pkg::beat_sel_t    wb_beat;
  cache_pkg::word_sel_t    req_word;
  cache_pkg::dirty_t       dirty_q;
  cache_pkg::dirty_t       dirty_left;
  logic                    req_is_write;
  logic                    write_hit;
  logic                    waiting;
  logic                    wb_loaded;
  logic                    addr_done;
  logic                    data_done;
  logic                    wb_finish;
  logic                    resp_take;
  logic                    last_fill;

  assign req_tag = req_q.addr[cache_pkg::word_addr_width-1 -: cache_pkg::tag_width];
  assign req_index = req_q.addr[cache_pkg::index_lsb +: cache_pkg::index_width];
  assign req_beat = req_q.addr[cache_pkg::word_sel_width +: cache_pkg::beat_sel_width];
  assign req_word = req_q.addr[cache_pkg::word_sel_width-1:0];
  assign req_is_write = |req_q.byte_en;

  assign cpu_req_ready = (state == cache_pkg::idle);
  assign write_hit = (state == cache_pkg::compare) && meta_hit && req_is_write;

  // Victim beats go out lowest first
  always_comb begin
    wb_beat = '0;
    for (int b = cache_pkg::beats_per_line - 1; b >= 0; b--) begin
      if (dirty_q[b]) begin
        wb_beat = cache_pkg::beat_sel_t'(b);
      end
    end
  end

  assign dirty_left = dirty_q & ~(cache_pkg::dirty_t'(1) << wb_beat);

  // A beat is retired once both the address and the data handshake are done
  assign wb_finish = (state == cache_pkg::write_back) && wb_loaded &&
                     (addr_done || mem_req_ready) && (data_done || mem_req_data_ready);
  assign resp_take = (state == cache_pkg::refill) && mem_resp_valid;
  assign last_fill = resp_take &&
                     (beat_count == cache_pkg::beat_sel_t'(cache_pkg::beats_per_line - 1));

  assign mem_req_rw = (state == cache_pkg::write_back);
  assign mem_req_valid = mem_req_rw ? (wb_loaded && !addr_done)
                                    : ((state == cache_pkg::refill) && !waiting);
  assign mem_req_data_valid = mem_req_rw && wb_loaded && !data_done;
  assign mem_req_addr = mem_req_rw ? {victim_tag_q, req_index, wb_beat}
                                   : {req_tag, req_index, beat_count};
  assign mem_req_data = data_read_beat;

  assign lookup_tag = req_tag;
  assign data_index = req_index;

  always_comb begin
    case (state)
      cache_pkg::write_back: data_beat = wb_beat;
      cache_pkg::refill:     data_beat = beat_count;
      default:               data_beat = req_beat;
    endcase
  end

  always_comb begin
    data_write = '0;
    data_write.en = write_hit || resp_take;
    data_write.fill = (state == cache_pkg::refill);
    data_write.word_sel = req_word;
    data_write.byte_en = req_q.byte_en;
    data_write.word_data = req_q.data;
    data_write.fill_data = mem_resp_data;
  end

  always_comb begin
    meta_index = req_index;
    meta_write_en = 1'b0;
    meta_write_entry = '0;
    if (state == cache_pkg::sweep) begin
      meta_index = sweep_count;
      meta_write_en = 1'b1;
    end else if (write_hit) begin
      meta_write_en = 1'b1;
      meta_write_entry.valid = 1'b1;
      meta_write_entry.dirty = meta_entry.dirty | (cache_pkg::dirty_t'(1) << req_beat);
      meta_write_entry.tag = req_tag;
    end else if (last_fill) begin
      // Line is complete, so it becomes valid and clean
      meta_write_en = 1'b1;
      meta_write_entry.valid = 1'b1;
      meta_write_entry.tag = req_tag;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      cache_pkg::sweep: begin
        if (sweep_count == cache_pkg::line_index_t'(cache_pkg::num_lines - 1)) begin
          next_state = cache_pkg::idle;
        end
      end
      cache_pkg::idle: begin
        if (cpu_req_valid) begin
          next_state = cache_pkg::lookup;
        end
      end
      cache_pkg::lookup: next_state = cache_pkg::compare;
      cache_pkg::compare: begin
        if (meta_hit) begin
          next_state = cache_pkg::idle;
        end else if (meta_entry.valid && |meta_entry.dirty) begin
          next_state = cache_pkg::write_back;
        end else begin
          next_state = cache_pkg::refill;
        end
      end
      cache_pkg::write_back: begin
        if (wb_finish && dirty_left == '0) begin
          next_state = cache_pkg::refill;
        end
      end
      cache_pkg::refill: begin
        if (last_fill) begin
          next_state = cache_pkg::lookup;
        end
      end
      default: next_state = cache_pkg::sweep;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::sweep;
      sweep_count <= '0;
      beat_count <= '0;
      dirty_q <= '0;
      waiting <= 1'b0;
      wb_loaded <= 1'b0;
      addr_done <= 1'b0;
      data_done <= 1'b0;
      cpu_resp_valid <= 1'b0;
    end else begin
      state <= next_state;
      cpu_resp_valid <= (state == cache_pkg::compare) && meta_hit;
      if (state == cache_pkg::sweep) begin
        sweep_count <= sweep_count + 1'b1;
      end
      if (state == cache_pkg::compare) begin
        dirty_q <= meta_entry.valid ? meta_entry.dirty : '0;
        beat_count <= '0;
        waiting <= 1'b0;
        wb_loaded <= 1'b0;
        addr_done <= 1'b0;
        data_done <= 1'b0;
      end
      // First cycle of each beat only reads it out of the data array
      if (state == cache_pkg::write_back) begin
        if (wb_finish) begin
          dirty_q <= dirty_left;
          wb_loaded <= 1'b0;
          addr_done <= 1'b0;
          data_done <= 1'b0;
        end else begin
          wb_loaded <= 1'b1;
          if (mem_req_valid && mem_req_ready) begin
            addr_done <= 1'b1;
          end
          if (mem_req_data_valid && mem_req_data_ready) begin
            data_done <= 1'b1;
          end
        end
      end
      if (state == cache_pkg::refill) begin
        if (resp_take) begin
          waiting <= 1'b0;
          beat_count <= beat_count + 1'b1;
        end else if (mem_req_valid && mem_req_ready) begin
          waiting <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_req_valid && cpu_req_ready) begin
      req_q <= cpu_req;
    end
    if (state == cache_pkg::compare) begin
      victim_tag_q <= meta_entry.tag;
    end
    // On a write this is the word as it was before the update
    if (state == cache_pkg::compare && meta_hit) begin
      cpu_resp_data <= data_read_beat[req_word*cache_pkg::word_width +: cache_pkg::word_width];
    end
  end

endmodule

`default_nettype wire

//--- logic/cache_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module cache_data_array (
  input  logic                    clk,
  input  cache_pkg::line_index_t  index,
  input  cache_pkg::beat_sel_t    beat,
  input  cache_pkg::data_write_t  write,
  output cache_pkg::beat_t        read_beat
);

  logic [cache_pkg::index_width+cache_pkg::beat_sel_width-1:0] addr;

  assign addr = {index, beat};

  // One bank per word position, so a beat is read or filled in one access
  for (genvar b = 0; b < cache_pkg::words_per_beat; b++) begin : g_bank
    cache_pkg::word_t mem [cache_pkg::bank_depth];
    cache_pkg::word_t read_q;
    logic             word_hit;

    assign word_hit = (write.word_sel == cache_pkg::word_sel_t'(b));

    always_ff @(posedge clk) begin
      if (write.en) begin
        if (write.fill) begin
          mem[addr] <= write.fill_data[b*cache_pkg::word_width +: cache_pkg::word_width];
        end else if (word_hit) begin
          for (int i = 0; i < cache_pkg::byte_count; i++) begin
            if (write.byte_en[i]) begin
              mem[addr][i*8 +: 8] <= write.word_data[i*8 +: 8];
            end
          end
        end
      end
    end

    // Read before write when both hit the same word
    always_ff @(posedge clk) begin
      read_q <= mem[addr];
    end

    assign read_beat[b*cache_pkg::word_width +: cache_pkg::word_width] = read_q;
  end

endmodule

`default_nettype wire

//--- logic/cache_meta_array.sv
`timescale 1ns/10ps
`default_nettype none

module cache_meta_array (
  input  logic                    clk,
  input  logic                    reset,
  input  cache_pkg::line_index_t  index,
  input  cache_pkg::tag_t         lookup_tag,
  input  logic                    write_en,
  input  cache_pkg::meta_entry_t  write_entry,
  output cache_pkg::meta_entry_t  entry,
  output logic                    hit
);

  cache_pkg::meta_entry_t entries [cache_pkg::num_lines];
  cache_pkg::tag_t        tag_q;

  // Writes come from the reset sweep and from the controller
  always_ff @(posedge clk) begin
    if (write_en) begin
      entries[index] <= write_entry;
    end
  end

  // Registered read port, so the entry shows up one cycle after the index
  always_ff @(posedge clk) begin
    if (reset) begin
      entry <= '0;
    end else begin
      entry <= entries[index];
    end
  end

  always_ff @(posedge clk) begin
    tag_q <= lookup_tag;
  end

  // Compare against the tag that was presented along with the index
  assign hit = entry.valid && (entry.tag == tag_q);

endmodule

`default_nettype wire

//--- logic/cache_pkg.sv
`default_nettype none

package cache_pkg;

  localparam int word_width = 32;
  localparam int byte_count = word_width / 8;
  localparam int word_addr_width = 30;

  localparam int num_lines = 64;
  localparam int beats_per_line = 4;
  localparam int words_per_beat = 4;

  // Derived geometry of the 512-bit line
  localparam int beat_width = word_width * words_per_beat;
  localparam int word_sel_width = $clog2(words_per_beat);
  localparam int beat_sel_width = $clog2(beats_per_line);
  localparam int index_width = $clog2(num_lines);
  localparam int index_lsb = word_sel_width + beat_sel_width;
  localparam int tag_width = word_addr_width - index_lsb - index_width;
  localparam int beat_addr_width = word_addr_width - word_sel_width;
  localparam int bank_depth = num_lines * beats_per_line;

  typedef logic [word_width-1:0] word_t;
  typedef logic [byte_count-1:0] byte_en_t;
  typedef logic [word_addr_width-1:0] word_addr_t;
  typedef logic [beat_width-1:0] beat_t;
  typedef logic [beat_addr_width-1:0] beat_addr_t;
  typedef logic [tag_width-1:0] tag_t;
  typedef logic [index_width-1:0] line_index_t;
  typedef logic [beat_sel_width-1:0] beat_sel_t;
  typedef logic [word_sel_width-1:0] word_sel_t;
  typedef logic [beats_per_line-1:0] dirty_t;

  // A request with all byte enables low is a read
  typedef struct packed {
    word_addr_t addr;
    word_t      data;
    byte_en_t   byte_en;
  } cpu_req_t;

  typedef struct packed {
    logic   valid;
    dirty_t dirty;
    tag_t   tag;
  } meta_entry_t;

  typedef struct packed {
    logic      en;
    logic      fill;
    word_sel_t word_sel;
    byte_en_t  byte_en;
    word_t     word_data;
    beat_t     fill_data;
  } data_write_t;

  typedef enum logic [2:0] {
    sweep,
    idle,
    lookup,
    compare,
    write_back,
    refill
  } cache_state_t;

endpackage

`default_nettype wire

//--- logic/cache_top.sv
`timescale 1ns/10ps
`default_nettype none

module cache_top (
  input  logic                   clk,
  input  logic                   reset,

  input  logic                   cpu_req_valid,
  output logic                   cpu_req_ready,
  input  cache_pkg::word_addr_t  cpu_req_addr,
  input  cache_pkg::word_t       cpu_req_data,
  input  cache_pkg::byte_en_t    cpu_req_write,
  output logic                   cpu_resp_valid,
  output cache_pkg::word_t       cpu_resp_data,

  output logic                   mem_req_valid,
  input  logic                   mem_req_ready,
  output cache_pkg::beat_addr_t  mem_req_addr,
  output logic                   mem_req_rw,
  output logic                   mem_req_data_valid,
  input  logic                   mem_req_data_ready,
  output cache_pkg::beat_t       mem_req_data,
  input  logic                   mem_resp_valid,
  input  cache_pkg::beat_t       mem_resp_data
);

  cache_pkg::cpu_req_t     cpu_req;
  cache_pkg::line_index_t  meta_index;
  cache_pkg::tag_t         lookup_tag;
  logic                    meta_write_en;
  cache_pkg::meta_entry_t  meta_write_entry;
  cache_pkg::meta_entry_t  meta_entry;
  logic                    meta_hit;
  cache_pkg::line_index_t  data_index;
  cache_pkg::beat_sel_t    data_beat;
  cache_pkg::data_write_t  data_write;
  cache_pkg::beat_t        data_read_beat;

  assign cpu_req = '{addr: cpu_req_addr, data: cpu_req_data, byte_en: cpu_req_write};

  cache_meta_array i_meta_array (
    .clk         (clk),
    .reset       (reset),
    .index       (meta_index),
    .lookup_tag  (lookup_tag),
    .write_en    (meta_write_en),
    .write_entry (meta_write_entry),
    .entry       (meta_entry),
    .hit         (meta_hit)
  );

  cache_data_array i_data_array (
    .clk       (clk),
    .index     (data_index),
    .beat      (data_beat),
    .write     (data_write),
    .read_beat (data_read_beat)
  );

  cache_controller i_controller (
    .clk                (clk),
    .reset              (reset),
    .cpu_req_valid      (cpu_req_valid),
    .cpu_req            (cpu_req),
    .cpu_req_ready      (cpu_req_ready),
    .cpu_resp_valid     (cpu_resp_valid),
    .cpu_resp_data      (cpu_resp_data),
    .mem_req_valid      (mem_req_valid),
    .mem_req_addr       (mem_req_addr),
    .mem_req_rw         (mem_req_rw),
    .mem_req_data_valid (mem_req_data_valid),
    .mem_req_data       (mem_req_data),
    .mem_req_ready      (mem_req_ready),
    .mem_req_data_ready (mem_req_data_ready),
    .mem_resp_valid     (mem_resp_valid),
    .mem_resp_data      (mem_resp_data),
    .meta_index         (meta_index),
    .lookup_tag         (lookup_tag),
    .meta_write_en      (meta_write_en),
    .meta_write_entry   (meta_write_entry),
    .meta_entry         (meta_entry),
    .meta_hit           (meta_hit),
    .data_index         (data_index),
    .data_beat          (data_beat),
    .data_write         (data_write),
    .data_read_beat     (data_read_beat)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e

verilator --binary --timing -Wno-fatal --top-module cache_tb -f cache_top.f -o cache_sim
./obj_dir/cache_sim > sim.log
cat sim.log

if grep -q "^Test OK$" sim.log; then
  exit 0
else
  exit 1
fi

//--- tb/cache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cache_tb;

  logic                  clk;
  logic                  reset;
  logic                  cpu_req_valid;
  logic                  cpu_req_ready;
  cache_pkg::word_addr_t cpu_req_addr;
  cache_pkg::word_t      cpu_req_data;
  cache_pkg::byte_en_t   cpu_req_write;
  logic                  cpu_resp_valid;
  cache_pkg::word_t      cpu_resp_data;
  logic                  mem_req_valid;
  logic                  mem_req_ready;
  cache_pkg::beat_addr_t mem_req_addr;
  logic                  mem_req_rw;
  logic                  mem_req_data_valid;
  logic                  mem_req_data_ready;
  cache_pkg::beat_t      mem_req_data;
  logic                  mem_resp_valid;
  cache_pkg::beat_t      mem_resp_data;

  integer seed = 16334;
  int errors = 0;
  int cycles = 0;
  int limit = 200;
  int tests_run = 0;
  int tests_passed = 0;
  int addr_wait = 0;
  int data_wait = 0;
  logic addr_fire = 1'b0;
  logic data_fire = 1'b0;
  logic addr_pend = 1'b0;
  logic data_pend = 1'b0;
  logic held_rw;
  cache_pkg::beat_addr_t held_addr;
  cache_pkg::beat_t held_data;

  cache_pkg::beat_t mem_model [cache_pkg::beat_addr_t];
  cache_pkg::word_t golden [cache_pkg::word_addr_t];
  cache_pkg::beat_addr_t rd_q [$];
  int rd_delay [$];
  cache_pkg::beat_addr_t wr_addr_q [$];
  cache_pkg::beat_t wr_data_q [$];
  logic [28:0] traffic_q [$];
  string trace_q [$];

  // Expected valid, tag and dirty state of each cache line
  logic shadow_valid [64];
  cache_pkg::tag_t shadow_tag [64];
  cache_pkg::dirty_t shadow_dirty [64];

  cache_top i_cache_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic count_error();
    errors++;
  endtask

  function automatic cache_pkg::word_t initial_word(input cache_pkg::word_addr_t a);
    return {2'b00, a} ^ 32'h5A5A0000;
  endfunction

  function automatic cache_pkg::word_t golden_word(input cache_pkg::word_addr_t a);
    if (golden.exists(a)) return golden[a];
    return initial_word(a);
  endfunction

  function automatic cache_pkg::beat_t read_mem(input cache_pkg::beat_addr_t a);
    cache_pkg::beat_t b;
    if (mem_model.exists(a)) return mem_model[a];
    for (int i = 0; i < 4; i++) begin
      b[i*32 +: 32] = initial_word({a, cache_pkg::word_sel_t'(i)});
    end
    return b;
  endfunction

  // Every written-back word must hold what the CPU last wrote there
  task automatic store_beat(input cache_pkg::beat_addr_t a, input cache_pkg::beat_t d);
    cache_pkg::word_t want;
    for (int i = 0; i < 4; i++) begin
      want = golden_word({a, cache_pkg::word_sel_t'(i)});
      assert (d[i*32 +: 32] == want) else begin
        $display("MISMATCH at %0t: write-back beat %h word %0d is %h, expected %h",
                 $time, a, i, d[i*32 +: 32], want);
        count_error();
      end
    end
    mem_model[a] = d;
  endtask

  // Handshakes at the coming edge follow from the values seen mid-cycle
  always @(negedge clk) begin
    if (addr_pend) begin
      assert (mem_req_valid && mem_req_addr == held_addr && mem_req_rw == held_rw) else begin
        $display("MISMATCH at %0t: memory request changed before it was accepted", $time);
        count_error();
      end
    end
    if (data_pend) begin
      assert (mem_req_data_valid && mem_req_data == held_data) else begin
        $display("MISMATCH at %0t: write data changed before it was accepted", $time);
        count_error();
      end
    end
    addr_fire = mem_req_valid && mem_req_ready;
    data_fire = mem_req_data_valid && mem_req_data_ready;
    addr_pend = mem_req_valid && !mem_req_ready;
    data_pend = mem_req_data_valid && !mem_req_data_ready;
    held_addr = mem_req_addr;
    held_rw = mem_req_rw;
    held_data = mem_req_data;
  end

  always @(posedge clk) begin
    #2;
    if (addr_fire) begin
      traffic_q.push_back({held_rw, held_addr});
      if (held_rw) begin
        wr_addr_q.push_back(held_addr);
      end else begin
        rd_q.push_back(held_addr);
        rd_delay.push_back({$random(seed)} % 4);
      end
    end
    if (data_fire) wr_data_q.push_back(held_data);
    while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
      store_beat(wr_addr_q.pop_front(), wr_data_q.pop_front());
    end
    mem_resp_valid = 1'b0;
    if (rd_q.size() > 0) begin
      if (rd_delay[0] == 0) begin
        mem_resp_valid = 1'b1;
        mem_resp_data = read_mem(rd_q.pop_front());
        void'(rd_delay.pop_front());
      end else begin
        rd_delay[0] = rd_delay[0] - 1;
      end
    end
    if (addr_fire) addr_wait = {$random(seed)} % 4;
    else if (addr_wait > 0) addr_wait--;
    if (data_fire) data_wait = {$random(seed)} % 4;
    else if (data_wait > 0) data_wait--;
    mem_req_ready = (addr_wait == 0);
    mem_req_data_ready = (data_wait == 0);
  end

  task automatic run_op(input bit is_write, input cache_pkg::word_addr_t addr,
                        input cache_pkg::word_t data, input cache_pkg::byte_en_t be,
                        input cache_pkg::word_t expected);
    cache_pkg::line_index_t idx;
    cache_pkg::tag_t tag;
    cache_pkg::beat_sel_t beat;
    logic hit;
    logic [28:0] want [$];
    int edges;
    cache_pkg::word_t merged;
    idx = addr[9:4];
    tag = addr[29:10];
    beat = addr[3:2];
    hit = shadow_valid[idx] && shadow_tag[idx] == tag;
    if (!hit) begin
      for (int b = 0; b < 4; b++) begin
        if (shadow_valid[idx] && shadow_dirty[idx][b]) begin
          want.push_back({1'b1, shadow_tag[idx], idx, cache_pkg::beat_sel_t'(b)});
        end
      end
      for (int b = 0; b < 4; b++) begin
        want.push_back({1'b0, tag, idx, cache_pkg::beat_sel_t'(b)});
      end
    end
    @(posedge clk);
    #2;
    traffic_q.delete();
    cpu_req_valid = 1'b1;
    cpu_req_addr = addr;
    cpu_req_data = is_write ? data : '0;
    cpu_req_write = is_write ? be : '0;
    @(negedge clk);
    while (!cpu_req_ready) @(negedge clk);
    @(posedge clk);
    #2;
    cpu_req_valid = 1'b0;
    edges = 0;
    @(negedge clk);
    while (!cpu_resp_valid) begin
      edges++;
      @(negedge clk);
    end
    assert (cpu_resp_data == expected) else begin
      $display("MISMATCH at %0t: address %h returned %h, expected %h",
               $time, addr, cpu_resp_data, expected);
      count_error();
    end
    if (hit) begin
      assert (edges == 2) else begin
        $display("MISMATCH at %0t: hit at %h answered after %0d cycles, expected 2",
                 $time, addr, edges);
        count_error();
      end
    end
    assert (traffic_q.size() == want.size()) else begin
      $display("MISMATCH at %0t: access to %h made %0d memory requests, expected %0d",
               $time, addr, traffic_q.size(), want.size());
      count_error();
    end
    for (int i = 0; i < want.size() && i < traffic_q.size(); i++) begin
      assert (traffic_q[i] == want[i]) else begin
        $display("MISMATCH at %0t: memory request %0d is %h, expected %h",
                 $time, i, traffic_q[i], want[i]);
        count_error();
      end
    end
    if (!hit) begin
      shadow_valid[idx] = 1'b1;
      shadow_tag[idx] = tag;
      shadow_dirty[idx] = '0;
    end
    if (is_write) begin
      shadow_dirty[idx][beat] = 1'b1;
      merged = golden_word(addr);
      for (int i = 0; i < 4; i++) begin
        if (be[i]) merged[i*8 +: 8] = data[i*8 +: 8];
      end
      golden[addr] = merged;
    end
  endtask

  task automatic report_test(input int num, input int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      tests_passed++;
      $display("test %0d: passed", num);
    end else begin
      $display("test %0d: failed with %0d errors", num, errors - err_mark);
    end
  endtask

  initial begin
    int fd;
    int edges;
    int tnum;
    int cur_test;
    int err_mark;
    string line;
    string op;
    cache_pkg::word_addr_t a;
    cache_pkg::word_t d;
    cache_pkg::byte_en_t be;
    cache_pkg::word_t expected;
    reset = 1'b1;
    cpu_req_valid = 1'b0;
    cpu_req_addr = '0;
    cpu_req_data = '0;
    cpu_req_write = '0;
    mem_req_ready = 1'b1;
    mem_req_data_ready = 1'b1;
    mem_resp_valid = 1'b0;
    mem_resp_data = '0;
    for (int i = 0; i < 64; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i] = '0;
      shadow_dirty[i] = '0;
    end
    fd = $fopen("tb/cache_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file tb/cache_trace.txt");
      count_error();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.substr(0, 0) != "#") trace_q.push_back(line);
      end
      $fclose(fd);
    end
    limit = 200 * trace_q.size() + 200;

    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    // Test 0 covers the reset sweep and counts the cycle in which reset falls as cycle 1
    edges = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
      assert (!cpu_resp_valid && !mem_req_valid && !mem_req_data_valid) else begin
        $display("MISMATCH at %0t: an output was valid during the reset sweep", $time);
        count_error();
      end
    end while (!cpu_req_ready && edges < 100);
    assert (edges == 64) else begin
      $display("MISMATCH at %0t: cpu_req_ready rose in cycle %0d after reset, expected 65",
               $time, edges + 1);
      count_error();
    end

    cur_test = 0;
    err_mark = 0;
    foreach (trace_q[k]) begin
      void'($sscanf(trace_q[k], "%d %s %h %h %h %h", tnum, op, a, d, be, expected));
      if (tnum != cur_test) begin
        report_test(cur_test, err_mark);
        cur_test = tnum;
        err_mark = errors;
      end
      run_op(op == "W", a, d, be, expected);
    end
    report_test(cur_test, err_mark);

    $display("%0d tests run, %0d passed, %0d errors", tests_run, tests_passed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/cache_trace.txt
# test op word_addr wdata byte_en expected
# expected is the read word, or the old word for a write
1 R 00000123 00000000 0 5A5A0123
1 R 00000121 00000000 0 5A5A0121
2 W 00000122 AABBCCDD 5 5A5A0122
2 R 00000122 00000000 0 5ABB01DD
2 W 0000012D 11223344 F 5A5A012D
2 R 0000012D 00000000 0 11223344
3 R 00000523 00000000 0 5A5A0523
3 R 00000122 00000000 0 5ABB01DD
3 R 0000012D 00000000 0 11223344
4 R 00001000 00000000 0 5A5A1000
4 W 00001001 CAFEF00D C 5A5A1001
4 R 00000401 00000000 0 5A5A0401
4 R 00001001 00000000 0 CAFE1001
4 R 3FFFFFFF 00000000 0 65A5FFFF
4 R 0ABCDEF0 00000000 0 50E6DEF0
